// File: Makefile
# Verilator build and run for the out-of-order core testbench

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_ooo_core
FILELIST  := project.f
LOG       := sim.log
SIM_BIN   := obj_dir/V$(TOP)
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, not the exit status of the binary
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: include/ooo_defs.svh
// core sizing and encoding constants
// widths, buffer depths and the accepted RISC-V opcodes

`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// datapath and register file
`define XLEN          32
`define REG_IDX_W     5
`define NUM_REGS      32

// reorder buffer and reservation station sizes
`define ROB_DEPTH     8
`define ROB_TAG_W     3
`define RS_DEPTH      4

// major opcodes taken by dispatch
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011

// funct3 codes shared by register and immediate forms
`define F3_ADD_SUB    3'b000
`define F3_SLL        3'b001
`define F3_SLT        3'b010
`define F3_XOR        3'b100
`define F3_SRL        3'b101
`define F3_OR         3'b110
`define F3_AND        3'b111

`endif

// File: project.f
+incdir+include
rtl/ooo_pkg.sv
rtl/alu_stage.sv
rtl/reservation_station.sv
rtl/reorder_buffer.sv
rtl/dispatch_unit.sv
rtl/ooo_core.sv
sim/commit_checker.sv
sim/tb_ooo_core.sv

// File: rtl/alu_stage.sv
// ALU stage
// computes the issued operation and registers the result onto the CDB

`timescale 1ns/1ps
`include "ooo_defs.svh"

module alu_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  ooo_pkg::dispatch_packet_t issue,
	output ooo_pkg::cdb_packet_t      cdb
);
	import ooo_pkg::*;

	logic [`XLEN-1:0]          op_a;
	logic [`XLEN-1:0]          op_b;
	logic [$clog2(`XLEN)-1:0]  shamt;
	logic [`XLEN-1:0]          result;

	// result register
	logic                      valid_q;
	rob_tag_t                  tag_q;
	logic [`XLEN-1:0]          value_q;

	assign op_a  = issue.src1.value;
	assign op_b  = issue.src2.value;
	// only the low five bits shift
	assign shamt = op_b[$clog2(`XLEN)-1:0];

	always_comb begin
		case (issue.alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			// signed compare
			ALU_SLT: result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLL: result = op_a << shamt;
			ALU_SRL: result = op_a >> shamt;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= issue.valid;
	end

	always_ff @(posedge clock) begin
		tag_q   <= issue.tag;
		value_q <= result;
	end

	assign cdb = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

// File: rtl/dispatch_unit.sv
// dispatch unit
// decodes each word, reads operands through the map table and
// register file, allocates the rob tag and raises the stall when full

`timescale 1ns/1ps
`include "ooo_defs.svh"

module dispatch_unit (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      inst_valid,
	input  ooo_pkg::inst_t            inst,
	input  logic                      rob_full,
	input  logic                      rs_full,
	input  ooo_pkg::rob_tag_t         alloc_tag,
	output ooo_pkg::rob_tag_t         rs1_rob_tag,
	output ooo_pkg::rob_tag_t         rs2_rob_tag,
	input  logic                      rs1_rob_ready,
	input  logic                      rs2_rob_ready,
	input  logic [`XLEN-1:0]          rs1_rob_value,
	input  logic [`XLEN-1:0]          rs2_rob_value,
	input  ooo_pkg::commit_packet_t   commit,
	output logic                      inst_stall,
	output ooo_pkg::dispatch_packet_t dispatch
);
	import ooo_pkg::*;

	// architectural state and rename map
	logic [`XLEN-1:0] reg_file [`NUM_REGS];
	logic             map_busy [`NUM_REGS];
	rob_tag_t         map_tag  [`NUM_REGS];

	logic             is_op;
	logic             is_op_imm;
	logic             accept;
	alu_op_e          alu_op;
	logic [`XLEN-1:0] imm;
	operand_t         src1;
	operand_t         src2;

	// register file if unmapped, else the rob entry
	function automatic operand_t read_src(input logic [`REG_IDX_W-1:0] idx,
			input logic rob_ready, input logic [`XLEN-1:0] rob_value);
		operand_t op;
		op.tag = map_busy[idx] ? map_tag[idx] : '0;
		if (idx == '0) begin
			op.ready = 1'b1;
			op.value = '0;
		end else if (map_busy[idx]) begin
			op.ready = rob_ready;
			op.value = rob_value;
		end else begin
			op.ready = 1'b1;
			op.value = reg_file[idx];
		end
		return op;
	endfunction

	//////////////////////////////////////////////////
	// decode and stall
	//////////////////////////////////////////////////

	assign is_op      = inst.r.opcode == `OPCODE_OP;
	assign is_op_imm  = inst.r.opcode == `OPCODE_OP_IMM;
	assign imm        = {{(`XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
	// stall on either structure full
	assign inst_stall = rob_full | rs_full;
	assign accept     = inst_valid & ~inst_stall;

	always_comb begin
		case (inst.r.funct3)
			// sub only exists in the register form
			`F3_ADD_SUB: alu_op = (is_op && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
			`F3_SLL:     alu_op = ALU_SLL;
			`F3_SLT:     alu_op = ALU_SLT;
			`F3_XOR:     alu_op = ALU_XOR;
			`F3_SRL:     alu_op = ALU_SRL;
			`F3_OR:      alu_op = ALU_OR;
			`F3_AND:     alu_op = ALU_AND;
			default:     alu_op = ALU_ADD;
		endcase
	end

	// rob read ports follow the map table
	assign rs1_rob_tag = map_tag[inst.r.rs1];
	assign rs2_rob_tag = map_tag[inst.r.rs2];

	always_comb begin
		src1 = read_src(inst.r.rs1, rs1_rob_ready, rs1_rob_value);
		if (is_op_imm)
			src2 = '{ready: 1'b1, tag: '0, value: imm};
		else
			src2 = read_src(inst.r.rs2, rs2_rob_ready, rs2_rob_value);
	end

	// other opcodes are accepted but never dispatched
	always_comb begin
		dispatch.valid  = accept & (is_op | is_op_imm);
		dispatch.alu_op = alu_op;
		dispatch.dest   = inst.r.rd;
		dispatch.tag    = alloc_tag;
		dispatch.src1   = src1;
		dispatch.src2   = src2;
	end

	//////////////////////////////////////////////////
	// register file and map table
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				reg_file[i] <= '0;
				map_busy[i] <= 1'b0;
			end
		end else begin
			if (commit.wr_en)
				reg_file[commit.dest] <= commit.value;
			// clear only if no younger writer took the register
			if (commit.valid && map_busy[commit.dest] && map_tag[commit.dest] == commit.tag)
				map_busy[commit.dest] <= 1'b0;
			// same-cycle dispatch wins over the clear
			if (dispatch.valid && dispatch.dest != '0)
				map_busy[dispatch.dest] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch.valid && dispatch.dest != '0)
			map_tag[dispatch.dest] <= alloc_tag;
	end

endmodule

// File: rtl/ooo_core.sv
// out-of-order integer core top level
// dispatch, reorder buffer, one reservation station and the ALU stage

`timescale 1ns/1ps
`include "ooo_defs.svh"

module ooo_core (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  inst_valid,
	input  ooo_pkg::inst_t        inst,
	output logic                  inst_stall,
	output logic                  commit_valid,
	output logic                  commit_wr_en,
	output logic [`REG_IDX_W-1:0] commit_wr_idx,
	output logic [`XLEN-1:0]      commit_wr_data
);
	import ooo_pkg::*;

	// dispatch to rob and rs
	dispatch_packet_t dispatch;
	rob_tag_t         alloc_tag;
	logic             rob_full;
	logic             rs_full;

	// rob operand read ports
	rob_tag_t         rs1_rob_tag;
	rob_tag_t         rs2_rob_tag;
	logic             rs1_rob_ready;
	logic             rs2_rob_ready;
	logic [`XLEN-1:0] rs1_rob_value;
	logic [`XLEN-1:0] rs2_rob_value;

	// execute and retire
	dispatch_packet_t issue;
	cdb_packet_t      cdb;
	commit_packet_t   commit;

	//////////////////////////////////////////////////
	// units
	//////////////////////////////////////////////////

	dispatch_unit u_dispatch (
		.clock         (clock),
		.reset         (reset),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.rob_full      (rob_full),
		.rs_full       (rs_full),
		.alloc_tag     (alloc_tag),
		.rs1_rob_tag   (rs1_rob_tag),
		.rs2_rob_tag   (rs2_rob_tag),
		.rs1_rob_ready (rs1_rob_ready),
		.rs2_rob_ready (rs2_rob_ready),
		.rs1_rob_value (rs1_rob_value),
		.rs2_rob_value (rs2_rob_value),
		.commit        (commit),
		.inst_stall    (inst_stall),
		.dispatch      (dispatch)
	);

	reorder_buffer u_rob (
		.clock         (clock),
		.reset         (reset),
		.dispatch      (dispatch),
		.cdb           (cdb),
		.rs1_rob_tag   (rs1_rob_tag),
		.rs2_rob_tag   (rs2_rob_tag),
		.rs1_rob_ready (rs1_rob_ready),
		.rs2_rob_ready (rs2_rob_ready),
		.rs1_rob_value (rs1_rob_value),
		.rs2_rob_value (rs2_rob_value),
		.rob_full      (rob_full),
		.alloc_tag     (alloc_tag),
		.commit        (commit)
	);

	reservation_station u_rs (
		.clock    (clock),
		.reset    (reset),
		.dispatch (dispatch),
		.cdb      (cdb),
		.rs_full  (rs_full),
		.issue    (issue)
	);

	alu_stage u_alu (
		.clock (clock),
		.reset (reset),
		.issue (issue),
		.cdb   (cdb)
	);

	// retire port split out of the commit packet
	assign commit_valid   = commit.valid;
	assign commit_wr_en   = commit.wr_en;
	assign commit_wr_idx  = commit.dest;
	assign commit_wr_data = commit.value;

endmodule

// File: rtl/ooo_pkg.sv
// shared types for the out-of-order core
// instruction views, operands and the packets between the units

`include "ooo_defs.svh"

package ooo_pkg;

	//////////////////////////////////////////////////
	// instruction word
	//////////////////////////////////////////////////

	// register-register layout
	typedef struct packed {
		logic [6:0]            funct7;
		logic [`REG_IDX_W-1:0] rs2;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [`REG_IDX_W-1:0] rd;
		logic [6:0]            opcode;
	} r_type_t;

	// register-immediate layout
	typedef struct packed {
		logic [11:0]           imm12;
		logic [`REG_IDX_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [`REG_IDX_W-1:0] rd;
		logic [6:0]            opcode;
	} i_type_t;

	// same 32 bits seen either way
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} inst_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	//////////////////////////////////////////////////
	// tags and packets
	//////////////////////////////////////////////////

	typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

	// value is meaningful once ready, else wait on tag
	typedef struct packed {
		logic             ready;
		rob_tag_t         tag;
		logic [`XLEN-1:0] value;
	} operand_t;

	typedef struct packed {
		logic                  valid;
		alu_op_e               alu_op;
		logic [`REG_IDX_W-1:0] dest;
		rob_tag_t              tag;
		operand_t              src1;
		operand_t              src2;
	} dispatch_packet_t;

	typedef struct packed {
		logic             valid;
		rob_tag_t         tag;
		logic [`XLEN-1:0] value;
	} cdb_packet_t;

	// wr_en already excludes x0
	typedef struct packed {
		logic                  valid;
		logic                  wr_en;
		logic [`REG_IDX_W-1:0] dest;
		rob_tag_t              tag;
		logic [`XLEN-1:0]      value;
	} commit_packet_t;

endpackage

// File: rtl/reorder_buffer.sv
// reorder buffer
// circular queue of in-flight results, filled from the CDB,
// read by dispatch and retired in program order from the head

`timescale 1ns/1ps
`include "ooo_defs.svh"

module reorder_buffer (
	input  logic                      clock,
	input  logic                      reset,
	input  ooo_pkg::dispatch_packet_t dispatch,
	input  ooo_pkg::cdb_packet_t      cdb,
	input  ooo_pkg::rob_tag_t         rs1_rob_tag,
	input  ooo_pkg::rob_tag_t         rs2_rob_tag,
	output logic                      rs1_rob_ready,
	output logic                      rs2_rob_ready,
	output logic [`XLEN-1:0]          rs1_rob_value,
	output logic [`XLEN-1:0]          rs2_rob_value,
	output logic                      rob_full,
	output ooo_pkg::rob_tag_t         alloc_tag,
	output ooo_pkg::commit_packet_t   commit
);
	import ooo_pkg::*;

	// queue pointers
	rob_tag_t            head;
	rob_tag_t            tail;
	logic [`ROB_TAG_W:0] count;

	// per entry state
	logic [`REG_IDX_W-1:0] dest_q  [`ROB_DEPTH];
	logic                  ready_q [`ROB_DEPTH];
	logic [`XLEN-1:0]      value_q [`ROB_DEPTH];

	operand_t rd1;
	operand_t rd2;

	// stored result, or the CDB result landing this cycle
	function automatic operand_t read_entry(input rob_tag_t tag);
		operand_t op;
		op.tag = tag;
		if (ready_q[tag]) begin
			op.ready = 1'b1;
			op.value = value_q[tag];
		end else begin
			op.ready = cdb.valid && cdb.tag == tag;
			op.value = cdb.value;
		end
		return op;
	endfunction

	//////////////////////////////////////////////////
	// read ports, allocation and commit
	//////////////////////////////////////////////////

	always_comb begin
		rd1 = read_entry(rs1_rob_tag);
		rd2 = read_entry(rs2_rob_tag);
	end

	assign rs1_rob_ready = rd1.ready;
	assign rs1_rob_value = rd1.value;
	assign rs2_rob_ready = rd2.ready;
	assign rs2_rob_value = rd2.value;

	assign rob_full  = count == (`ROB_TAG_W+1)'(`ROB_DEPTH);
	assign alloc_tag = tail;

	// head retires as soon as its result is in
	always_comb begin
		commit.valid = (count != '0) && ready_q[head];
		commit.dest  = dest_q[head];
		commit.wr_en = commit.valid && commit.dest != '0;
		commit.tag   = head;
		commit.value = value_q[head];
	end

	//////////////////////////////////////////////////
	// state update
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < `ROB_DEPTH; i++)
				ready_q[i] <= 1'b0;
		end else begin
			if (dispatch.valid) begin
				ready_q[tail] <= 1'b0;
				tail          <= tail + 1'b1;
			end
			// cdb never targets the free tail slot
			if (cdb.valid)
				ready_q[cdb.tag] <= 1'b1;
			if (commit.valid)
				head <= head + 1'b1;
			case ({dispatch.valid, commit.valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// destination and result payload
	always_ff @(posedge clock) begin
		if (dispatch.valid)
			dest_q[tail] <= dispatch.dest;
		if (cdb.valid)
			value_q[cdb.tag] <= cdb.value;
	end

endmodule

// File: rtl/reservation_station.sv
// reservation station
// holds dispatched ALU ops until both operands arrive on the CDB,
// then issues the lowest ready entry, one per cycle

`timescale 1ns/1ps
`include "ooo_defs.svh"

module reservation_station (
	input  logic                      clock,
	input  logic                      reset,
	input  ooo_pkg::dispatch_packet_t dispatch,
	input  ooo_pkg::cdb_packet_t      cdb,
	output logic                      rs_full,
	output ooo_pkg::dispatch_packet_t issue
);
	import ooo_pkg::*;

	logic                         valid_q [`RS_DEPTH];
	dispatch_packet_t             entry_q [`RS_DEPTH];
	dispatch_packet_t             incoming;
	logic [$clog2(`RS_DEPTH)-1:0] free_idx;
	logic [$clog2(`RS_DEPTH)-1:0] issue_idx;
	logic                         issue_found;

	// wake a waiting operand on a matching broadcast
	function automatic operand_t capture(input operand_t op, input cdb_packet_t bus);
		operand_t res;
		res = op;
		if (!op.ready && bus.valid && bus.tag == op.tag) begin
			res.ready = 1'b1;
			res.value = bus.value;
		end
		return res;
	endfunction

	//////////////////////////////////////////////////
	// slot search and issue select
	//////////////////////////////////////////////////

	// scan downward so the lowest index wins
	always_comb begin
		rs_full     = 1'b1;
		free_idx    = '0;
		issue_found = 1'b0;
		issue_idx   = '0;
		for (int i = `RS_DEPTH-1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				rs_full  = 1'b0;
				free_idx = i[$clog2(`RS_DEPTH)-1:0];
			end
			if (valid_q[i] && entry_q[i].src1.ready && entry_q[i].src2.ready) begin
				issue_found = 1'b1;
				issue_idx   = i[$clog2(`RS_DEPTH)-1:0];
			end
		end
	end

	always_comb begin
		issue       = entry_q[issue_idx];
		issue.valid = issue_found;
	end

	// new entry also sees this cycle's broadcast
	always_comb begin
		incoming      = dispatch;
		incoming.src1 = capture(dispatch.src1, cdb);
		incoming.src2 = capture(dispatch.src2, cdb);
	end

	//////////////////////////////////////////////////
	// entry state
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RS_DEPTH; i++)
				valid_q[i] <= 1'b0;
		end else begin
			// issued slot frees one edge after issue
			if (issue_found)
				valid_q[issue_idx] <= 1'b0;
			if (dispatch.valid)
				valid_q[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			entry_q[i].src1 <= capture(entry_q[i].src1, cdb);
			entry_q[i].src2 <= capture(entry_q[i].src2, cdb);
		end
		if (dispatch.valid)
			entry_q[free_idx] <= incoming;
	end

endmodule

// File: sim/commit_checker.sv
// commit checker
// in-order register model of the accepted stream, compared against every commit

`timescale 1ns/1ps
`include "ooo_defs.svh"

module commit_checker (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  inst_valid,
	input  logic [`XLEN-1:0]      inst,
	input  logic                  inst_stall,
	input  logic                  commit_valid,
	input  logic                  commit_wr_en,
	input  logic [`REG_IDX_W-1:0] commit_wr_idx,
	input  logic [`XLEN-1:0]      commit_wr_data,
	input  logic                  end_check,
	output int                    pending,
	output int                    value_errors,
	output int                    protocol_errors
);
	// one expected retirement
	typedef struct packed {
		logic [`REG_IDX_W-1:0] idx;
		logic                  wr_en;
		logic [`XLEN-1:0]      data;
	} expect_t;

	logic [`XLEN-1:0] model_regs [`NUM_REGS];
	expect_t          expect_q [$];
	logic             after_reset;
	logic             end_done;
	int               stall_cycles;

	// reference ALU from the ISA rules
	function automatic logic [`XLEN-1:0] alu_result(input logic [2:0] funct3,
			input logic sub, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic [`XLEN-1:0] r;
		case (funct3)
			3'b000:  r = sub ? a - b : a + b;
			3'b001:  r = a << b[4:0];
			3'b010:  r = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			3'b100:  r = a ^ b;
			3'b101:  r = a >> b[4:0];
			3'b110:  r = a | b;
			3'b111:  r = a & b;
			default: r = '0;
		endcase
		return r;
	endfunction

	//////////////////////////////////////////////////
	// model and compare
	//////////////////////////////////////////////////

	// program order update where other opcodes leave no trace
	task automatic model_accept(input logic [`XLEN-1:0] w);
		logic [6:0]            opcode;
		logic [`REG_IDX_W-1:0] rd;
		logic [`XLEN-1:0]      a;
		logic [`XLEN-1:0]      b;
		logic [`XLEN-1:0]      r;
		expect_t               e;
		opcode = w[6:0];
		rd     = w[11:7];
		a      = model_regs[w[19:15]];
		if (opcode == `OPCODE_OP || opcode == `OPCODE_OP_IMM) begin
			if (opcode == `OPCODE_OP) begin
				b = model_regs[w[24:20]];
				r = alu_result(w[14:12], w[30], a, b);
			end else begin
				b = {{(`XLEN-12){w[31]}}, w[31:20]};
				r = alu_result(w[14:12], 1'b0, a, b);
			end
			// x0 stays zero
			if (rd != '0)
				model_regs[rd] = r;
			e.idx   = rd;
			e.wr_en = rd != '0;
			e.data  = r;
			expect_q.push_back(e);
		end
	endtask

	task automatic check_commit();
		expect_t e;
		if (expect_q.size() == 0) begin
			$display("commit to x%0d at %0t with no accepted instruction outstanding",
				commit_wr_idx, $time);
			protocol_errors++;
		end else begin
			e = expect_q.pop_front();
			if (commit_wr_idx !== e.idx || commit_wr_en !== e.wr_en
					|| commit_wr_data !== e.data) begin
				$display("[ERROR] %0t: commit x%0d en=%b data=%h, expected x%0d en=%b data=%h",
					$time, commit_wr_idx, commit_wr_en, commit_wr_data, e.idx, e.wr_en, e.data);
				value_errors++;
			end
		end
	endtask

	task automatic final_report();
		end_done = 1'b1;
		if (expect_q.size() != 0) begin
			$display("%0d accepted instructions never committed", expect_q.size());
			protocol_errors += expect_q.size();
		end
		// the burst must have filled a structure
		if (stall_cycles == 0) begin
			$display("inst_stall never went high during the run");
			protocol_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// sampling at the rising edge
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++)
				model_regs[i] = '0;
			expect_q.delete();
			after_reset     = 1'b1;
			end_done        = 1'b0;
			stall_cycles    = 0;
			pending         = 0;
			value_errors    = 0;
			protocol_errors = 0;
		end else begin
			// first edge out of reset
			if (after_reset) begin
				after_reset = 1'b0;
				if (commit_valid !== 1'b0 || commit_wr_en !== 1'b0
						|| inst_stall !== 1'b0) begin
					$display({"[ERROR] %0t: after reset commit_valid=%b commit_wr_en=%b",
						" inst_stall=%b, expected 0"},
						$time, commit_valid, commit_wr_en, inst_stall);
					value_errors++;
				end
			end
			if (inst_stall)
				stall_cycles++;
			// older instruction retires before the new one is modeled
			if (commit_valid)
				check_commit();
			if (inst_valid && !inst_stall)
				model_accept(inst);
			pending = expect_q.size();
			if (end_check && !end_done)
				final_report();
		end
	end

endmodule

// File: sim/tb_ooo_core.sv
// testbench for the out-of-order core
// applies an instruction table under stall with random idle gaps

`timescale 1ns/1ps
`include "ooo_defs.svh"

module tb_ooo_core;

	localparam int TABLE_LEN      = 30;
	localparam int TIMEOUT_CYCLES = TABLE_LEN * 20 + 100;
	localparam int QUIET_CYCLES   = 10;

	// burst entries get no idle gap before them
	typedef struct packed {
		logic             burst;
		logic [`XLEN-1:0] word;
	} stim_t;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  inst_valid;
	ooo_pkg::inst_t        inst;
	logic                  inst_stall;
	logic                  commit_valid;
	logic                  commit_wr_en;
	logic [`REG_IDX_W-1:0] commit_wr_idx;
	logic [`XLEN-1:0]      commit_wr_data;
	logic                  end_check;
	int                    pending;
	int                    value_errors;
	int                    protocol_errors;
	int                    cycle_count = 0;
	int                    gap;
	stim_t                 stim [TABLE_LEN];

	always #5 clock = ~clock;

	ooo_core u_dut (
		.clock          (clock),
		.reset          (reset),
		.inst_valid     (inst_valid),
		.inst           (inst),
		.inst_stall     (inst_stall),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data)
	);

	commit_checker u_checker (
		.clock           (clock),
		.reset           (reset),
		.inst_valid      (inst_valid),
		.inst            (inst),
		.inst_stall      (inst_stall),
		.commit_valid    (commit_valid),
		.commit_wr_en    (commit_wr_en),
		.commit_wr_idx   (commit_wr_idx),
		.commit_wr_data  (commit_wr_data),
		.end_check       (end_check),
		.pending         (pending),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors)
	);

	function automatic logic [`XLEN-1:0] r_type_word(input logic [6:0] funct7,
			input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] funct3,
			input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, `OPCODE_OP};
	endfunction

	function automatic logic [`XLEN-1:0] i_type_word(input logic [11:0] imm,
			input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {imm, rs1, funct3, rd, `OPCODE_OP_IMM};
	endfunction

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////

	// each entry holds a burst flag and an instruction word
	task automatic load_program();
		stim[0]  = {1'b0, i_type_word(12'd100, 5'd0, `F3_ADD_SUB, 5'd1)};
		stim[1]  = {1'b0, i_type_word(12'hff9, 5'd0, `F3_ADD_SUB, 5'd2)};
		stim[2]  = {1'b0, r_type_word(7'h00, 5'd2, 5'd1, `F3_ADD_SUB, 5'd3)};
		stim[3]  = {1'b0, r_type_word(7'h20, 5'd1, 5'd2, `F3_ADD_SUB, 5'd4)};
		// negative against positive in both orders
		stim[4]  = {1'b0, r_type_word(7'h00, 5'd1, 5'd2, `F3_SLT, 5'd5)};
		stim[5]  = {1'b0, r_type_word(7'h00, 5'd2, 5'd1, `F3_SLT, 5'd6)};
		stim[6]  = {1'b0, r_type_word(7'h00, 5'd3, 5'd1, `F3_AND, 5'd7)};
		stim[7]  = {1'b0, r_type_word(7'h00, 5'd4, 5'd2, `F3_OR, 5'd8)};
		stim[8]  = {1'b0, r_type_word(7'h00, 5'd4, 5'd3, `F3_XOR, 5'd9)};
		stim[9]  = {1'b0, i_type_word(12'd3, 5'd0, `F3_ADD_SUB, 5'd10)};
		stim[10] = {1'b0, r_type_word(7'h00, 5'd10, 5'd1, `F3_SLL, 5'd11)};
		stim[11] = {1'b0, r_type_word(7'h00, 5'd10, 5'd2, `F3_SRL, 5'd12)};
		stim[12] = {1'b0, i_type_word(12'hf9c, 5'd4, `F3_SLT, 5'd13)};
		stim[13] = {1'b0, i_type_word(12'hfff, 5'd9, `F3_XOR, 5'd14)};
		// x20 is never written
		stim[14] = {1'b0, i_type_word(12'h123, 5'd20, `F3_OR, 5'd15)};
		stim[15] = {1'b0, i_type_word(12'h0f0, 5'd2, `F3_AND, 5'd16)};
		stim[16] = {1'b0, r_type_word(7'h00, 5'd2, 5'd1, `F3_ADD_SUB, 5'd0)};
		stim[17] = {1'b0, r_type_word(7'h00, 5'd1, 5'd0, `F3_ADD_SUB, 5'd17)};
		// load opcode is dropped
		stim[18] = {1'b0, 32'h0000_2083};
		// dependent burst with no idle cycles
		stim[19] = {1'b1, i_type_word(12'd5, 5'd1, `F3_ADD_SUB, 5'd18)};
		stim[20] = {1'b1, r_type_word(7'h00, 5'd18, 5'd18, `F3_ADD_SUB, 5'd18)};
		stim[21] = {1'b1, r_type_word(7'h20, 5'd2, 5'd18, `F3_ADD_SUB, 5'd19)};
		stim[22] = {1'b1, r_type_word(7'h00, 5'd19, 5'd18, `F3_ADD_SUB, 5'd18)};
		stim[23] = {1'b1, r_type_word(7'h00, 5'd18, 5'd19, `F3_XOR, 5'd19)};
		// branch opcode is dropped
		stim[24] = {1'b1, 32'h0020_8063};
		stim[25] = {1'b1, r_type_word(7'h00, 5'd18, 5'd19, `F3_SLT, 5'd21)};
		stim[26] = {1'b1, r_type_word(7'h00, 5'd18, 5'd18, `F3_ADD_SUB, 5'd18)};
		stim[27] = {1'b1, r_type_word(7'h00, 5'd10, 5'd18, `F3_SRL, 5'd22)};
		stim[28] = {1'b1, r_type_word(7'h00, 5'd21, 5'd22, `F3_OR, 5'd23)};
		stim[29] = {1'b1, r_type_word(7'h00, 5'd18, 5'd23, `F3_ADD_SUB, 5'd24)};
	endtask

	//////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d commits outstanding",
				TIMEOUT_CYCLES, pending);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		reset      = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		end_check  = 1'b0;
		void'($urandom(32'h9610));
		load_program();
		repeat (4) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			gap        = stim[i].burst ? 0 : $urandom % 3;
			inst_valid = 1'b0;
			repeat (gap) @(negedge clock);
			inst_valid = 1'b1;
			inst       = stim[i].word;
			// stall depends on state only and is stable here
			while (inst_stall)
				@(negedge clock);
			@(negedge clock);
		end
		inst_valid = 1'b0;
		inst       = '0;
		// drain, then watch for stray commits
		while (pending != 0)
			@(negedge clock);
		repeat (QUIET_CYCLES) @(negedge clock);
		end_check = 1'b1;
		@(negedge clock);
		$display("summary: %0d value errors, %0d protocol errors",
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
